// File: bench/clock_gen.sv
`default_nettype none

module clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;	// Released after two rising edges
	end

	always #50 clock = ~clock;

endmodule

`default_nettype wire

// File: bench/cpu_properties.sv
`default_nettype none

// Four-phase rules on both sides of the instruction queue
module cpu_properties (
	input logic clock,
	input logic reset,
	input logic in_req,
	input logic in_ack,
	input cpu_pkg::pc_t in_pc,
	input cpu_pkg::word_t in_insn,
	input logic in_last,
	input logic out_req,
	input logic out_ack,
	input cpu_pkg::pc_t out_pc,
	input cpu_pkg::word_t out_insn,
	input logic out_last
);
	import cpu_pkg::*;

	in_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(in_ack) |-> in_req) else $error("fetch link ack rose without req");
	in_req_holds: assert property (@(posedge clock) disable iff (reset)
		in_req && !in_ack |=> in_req && $stable(in_pc) && $stable(in_insn) && $stable(in_last))
		else $error("fetch link req or data changed before ack");
	in_ack_holds: assert property (@(posedge clock) disable iff (reset)
		in_ack && in_req |=> in_ack) else $error("fetch link ack fell while req was high");

	out_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
		$rose(out_ack) |-> out_req) else $error("issue link ack rose without req");
	out_req_holds: assert property (@(posedge clock) disable iff (reset)
		out_req && !out_ack |=> out_req && $stable(out_pc) && $stable(out_insn)
		&& $stable(out_last)) else $error("issue link req or data changed before ack");
	out_ack_holds: assert property (@(posedge clock) disable iff (reset)
		out_ack && out_req |=> out_ack) else $error("issue link ack fell while req was high");

endmodule

bind insn_queue cpu_properties handshake_checks (
	.clock(clock), .reset(reset),
	.in_req(in_link.req), .in_ack(in_link.ack), .in_pc(in_link.pc),
	.in_insn(in_link.insn), .in_last(in_link.last),
	.out_req(out_link.req), .out_ack(out_link.ack), .out_pc(out_link.pc),
	.out_insn(out_link.insn), .out_last(out_link.last)
);

`default_nettype wire

// File: bench/cpu_tb.sv
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	logic clock;
	logic reset;
	logic load_en;
	imem_addr_t load_addr;
	word_t load_data;
	logic start;
	imem_addr_t prog_length;
	logic retire_valid;
	pc_t retire_pc;
	logic retire_we;
	reg_addr_t retire_rd;
	word_t retire_value;
	logic done;

	word_t model_regs [32];
	word_t program_words [$];
	pc_t exp_pc [$];
	logic exp_we [$];
	reg_addr_t exp_rd [$];
	word_t exp_value [$];
	logic done_due;
	logic done_prev;
	int errors;
	int timeouts;

	clock_gen clocks (.clock(clock), .reset(reset));

	cpu_top UUT (
		.clock(clock), .reset(reset), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .start(start), .prog_length(prog_length),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
		.retire_rd(retire_rd), .retire_value(retire_value), .done(done)
	);

	function automatic word_t r_type(input logic [5:0] fn, input int rd, input int rs,
			input int rt, input int sh);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic word_t i_type(input logic [5:0] op, input int rt, input int rs,
			input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	// MIPS semantics of one word, applied to the model register file
	function automatic void model_step(input word_t w, output logic we, output reg_addr_t dest,
			output word_t value);
		logic [15:0] imm;
		word_t a;
		word_t b;
		word_t sext;
		logic known;
		imm = w[15:0];
		a = model_regs[w[25:21]];
		b = model_regs[w[20:16]];
		sext = {{16{imm[15]}}, imm};
		known = 1'b1;
		dest = w[20:16];
		value = '0;
		case (w[31:26])
			OP_RTYPE: begin
				dest = w[15:11];
				case (w[5:0])
					FN_ADD, FN_ADDU: value = a + b;
					FN_SUB, FN_SUBU: value = a - b;
					FN_AND: value = a & b;
					FN_OR: value = a | b;
					FN_XOR: value = a ^ b;
					FN_NOR: value = ~(a | b);
					FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_SLTU: value = (a < b) ? 32'd1 : 32'd0;
					FN_SLL: value = b << w[10:6];
					FN_SRL: value = b >> w[10:6];
					FN_SRA: value = $signed(b) >>> w[10:6];
					default: known = 1'b0;
				endcase
			end
			OP_ADDIU: value = a + sext;
			OP_SLTI: value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			OP_ORI: value = a | {16'h0, imm};
			OP_XORI: value = a ^ {16'h0, imm};
			OP_LUI: value = {imm, 16'h0};
			default: known = 1'b0;
		endcase
		we = known && (dest != 0);	// Register 0 is never written
		if (we) begin
			model_regs[dest] = value;
		end
	endfunction

	function automatic word_t random_insn();
		logic [5:0] fns [13];
		logic [5:0] ops [5];
		fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
			FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
		ops = '{OP_ADDIU, OP_SLTI, OP_ORI, OP_XORI, OP_LUI};
		if ($urandom % 2 == 0) begin
			return r_type(fns[$urandom % 13], $urandom % 32, $urandom % 32, $urandom % 32,
				$urandom % 32);
		end
		return i_type(ops[$urandom % 5], $urandom % 32, $urandom % 32, $urandom % 65536);
	endfunction

	task automatic add_insn(input word_t w);
		logic we;
		reg_addr_t dest;
		word_t value;
		model_step(w, we, dest, value);
		exp_pc.push_back(pc_t'(program_words.size() * 4));
		exp_we.push_back(we);
		exp_rd.push_back(dest);
		exp_value.push_back(value);
		program_words.push_back(w);
	endtask

	task automatic compare(input string name, input word_t got, input word_t expected);
		assert (got == expected) else begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic run_program();
		int n;
		int limit;
		foreach (program_words[i]) begin
			@(posedge clock);
			load_en <= 1'b1;
			load_addr <= imem_addr_t'(i);
			load_data <= program_words[i];
		end
		@(posedge clock);
		load_en <= 1'b0;
		prog_length <= imem_addr_t'(program_words.size());
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		limit = 40 * program_words.size() + 50;
		n = 0;
		while (!(done && exp_pc.size() == 0) && n < limit) begin
			@(posedge clock);
			n++;
		end
		if (n >= limit) begin
			timeouts++;
			$display("Timeout: program of %0d words never finished", program_words.size());
			exp_pc.delete();
			exp_we.delete();
			exp_rd.delete();
			exp_value.delete();
		end
		program_words.delete();
		repeat (3) @(posedge clock);
	endtask

	// Retire checker
	always @(posedge clock) begin
		if (reset) begin
			done_due = 1'b0;
			done_prev = 1'b0;
		end else begin
			if (done && !done_prev) begin
				assert (done_due) else begin
					errors++;
					$display("done rose at a time other than right after the final retire");
				end
			end
			if (done_due) begin
				compare("done", word_t'(done), 32'd1);
			end
			done_due = 1'b0;
			done_prev = done;
			if (retire_valid && exp_pc.size() == 0) begin
				errors++;
				$display("Unexpected retire at pc %h with no instruction pending", retire_pc);
			end else if (retire_valid) begin
				compare("done", word_t'(done), 32'd0);	// Program still running
				compare("retire_pc", retire_pc, exp_pc.pop_front());
				compare("retire_we", word_t'(retire_we), word_t'(exp_we[0]));
				if (exp_we[0]) begin
					compare("retire_rd", word_t'(retire_rd), word_t'(exp_rd[0]));
					compare("retire_value", retire_value, exp_value[0]);
				end
				void'(exp_we.pop_front());
				void'(exp_rd.pop_front());
				void'(exp_value.pop_front());
				done_due = (exp_pc.size() == 0);
			end
		end
	end

	initial begin
		int n;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		prog_length = '0;
		errors = 0;
		timeouts = 0;
		foreach (model_regs[i]) model_regs[i] = '0;
		void'($urandom(81));
		n = 0;
		while (reset && n < 10) begin
			@(posedge clock);
			n++;
		end
		if (reset) begin
			timeouts++;
			$display("Timeout: reset was never released");
		end
		// Idle core stays quiet before start
		repeat (5) begin
			@(posedge clock);
			compare("retire_valid", word_t'(retire_valid), 32'd0);
			compare("retire_we", word_t'(retire_we), 32'd0);
			compare("done", word_t'(done), 32'd0);
		end

		add_insn(i_type(OP_ADDIU, 1, 0, 16'h1234));
		add_insn(i_type(OP_ADDIU, 2, 0, 16'hfffb));
		add_insn(i_type(OP_ADDIU, 3, 0, 16'h7fff));
		add_insn(r_type(FN_ADDU, 4, 1, 2, 0));
		add_insn(r_type(FN_SUBU, 5, 2, 1, 0));
		add_insn(r_type(FN_ADD, 6, 3, 3, 0));
		add_insn(r_type(FN_SUB, 7, 1, 3, 0));
		add_insn(r_type(FN_AND, 8, 1, 2, 0));
		add_insn(r_type(FN_OR, 9, 1, 2, 0));
		add_insn(r_type(FN_XOR, 10, 1, 2, 0));
		add_insn(r_type(FN_NOR, 11, 1, 2, 0));
		run_program();

		add_insn(r_type(FN_SLL, 12, 0, 2, 4));
		add_insn(r_type(FN_SRL, 13, 0, 2, 4));
		add_insn(r_type(FN_SRA, 14, 0, 2, 4));	// r2 is negative
		add_insn(r_type(FN_SLT, 15, 2, 1, 0));
		add_insn(r_type(FN_SLTU, 16, 2, 1, 0));
		add_insn(i_type(OP_SLTI, 17, 1, 16'hffff));
		add_insn(i_type(OP_SLTI, 18, 2, 16'h0000));
		add_insn(i_type(OP_LUI, 19, 0, 16'h8001));
		add_insn(i_type(OP_ORI, 19, 19, 16'habcd));
		add_insn(i_type(OP_XORI, 20, 19, 16'hffff));
		run_program();

		add_insn(i_type(OP_ADDIU, 0, 0, 16'h0055));
		add_insn(r_type(FN_ADDU, 0, 1, 2, 0));
		add_insn(r_type(FN_ADDU, 21, 0, 0, 0));
		add_insn(i_type(OP_ORI, 22, 0, 16'h0007));
		add_insn(32'h0000_0000);	// NOP
		add_insn(32'h8c22_1234);	// Load opcode, not kept
		add_insn(r_type(6'b011000, 24, 1, 2, 0));	// Multiply funct
		add_insn(i_type(OP_ADDIU, 23, 0, 16'h0001));
		run_program();

		for (int i = 0; i < 24; i++) begin
			add_insn(random_insn());
		end
		run_program();

		$display("Checks finished: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none

module alu (
	input cpu_pkg::alu_op_t op,
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input logic [4:0] shamt,
	output cpu_pkg::word_t result
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;	// Wraps, no overflow trap
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = word_t'($signed(a) < $signed(b));
			ALU_SLTU: result = word_t'(a < b);
			// Shifts act on the rt operand
			ALU_SLL: result = b << shamt;
			ALU_SRL: result = b >> shamt;
			ALU_SRA: result = $signed(b) >>> shamt;
			ALU_LUI: result = b << 16;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int IMEM_DEPTH = 256;
	localparam int IMEM_ADDR_WIDTH = 8;
	localparam int QUEUE_DEPTH = 4;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI = 6'b001010;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_XORI = 6'b001110;
	localparam logic [5:0] OP_LUI = 6'b001111;

	// R-type function field
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_NOR = 6'b100111;
	localparam logic [5:0] FN_SLT = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_SRA = 6'b000011;

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [31:0] pc_t;	// Byte address
	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;	// Word index

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_t;

endpackage

`default_nettype wire

// File: hdl/cpu_top.sv
`default_nettype none

module cpu_top (
	input logic clock,
	input logic reset,
	input logic load_en,
	input cpu_pkg::imem_addr_t load_addr,
	input cpu_pkg::word_t load_data,
	input logic start,
	input cpu_pkg::imem_addr_t prog_length,
	output logic retire_valid,
	output cpu_pkg::pc_t retire_pc,
	output logic retire_we,
	output cpu_pkg::reg_addr_t retire_rd,
	output cpu_pkg::word_t retire_value,
	output logic done
);
	import cpu_pkg::*;

	imem_addr_t read_addr;
	word_t read_data;

	insn_link_if fetch_link ();
	insn_link_if issue_link ();

	insn_memory imem (
		.clock(clock),
		.write_en(load_en),
		.write_addr(load_addr),
		.write_data(load_data),
		.read_addr(read_addr),
		.read_data(read_data)
	);

	fetch_unit fetch (
		.clock(clock),
		.reset(reset),
		.start(start),
		.prog_length(prog_length),
		.read_addr(read_addr),
		.read_data(read_data),
		.link(fetch_link.sender)
	);

	// Decouples fetch from execute
	insn_queue queue (
		.clock(clock),
		.reset(reset),
		.in_link(fetch_link.receiver),
		.out_link(issue_link.sender)
	);

	execute_unit execute (
		.clock(clock),
		.reset(reset),
		.link(issue_link.receiver),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_we(retire_we),
		.retire_rd(retire_rd),
		.retire_value(retire_value),
		.done(done)
	);

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`default_nettype none

module execute_unit (
	input logic clock,
	input logic reset,
	insn_link_if.receiver link,
	output logic retire_valid,
	output cpu_pkg::pc_t retire_pc,
	output logic retire_we,
	output cpu_pkg::reg_addr_t retire_rd,
	output cpu_pkg::word_t retire_value,
	output logic done
);
	import cpu_pkg::*;

	word_t regs [32];

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	reg_addr_t dest;
	logic [4:0] shamt;
	logic [15:0] imm;
	word_t imm_sext;
	word_t imm_zext;
	word_t rs_data;
	word_t rt_data;
	word_t operand_b;
	word_t result;
	alu_op_t op;
	logic write_en;
	logic accept;
	logic ack;
	logic retire_last;

	assign opcode = link.insn[31:26];
	assign rs = link.insn[25:21];
	assign rt = link.insn[20:16];
	assign rd = link.insn[15:11];
	assign shamt = link.insn[10:6];
	assign funct = link.insn[5:0];
	assign imm = link.insn[15:0];
	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_zext = {16'b0, imm};

	assign rs_data = (rs == '0) ? '0 : regs[rs];
	assign rt_data = (rt == '0) ? '0 : regs[rt];

	always_comb begin
		op = ALU_ADD;
		operand_b = rt_data;
		dest = rt;
		write_en = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				dest = rd;
				write_en = 1'b1;
				case (funct)
					FN_ADD, FN_ADDU: op = ALU_ADD;	// No overflow trap
					FN_SUB, FN_SUBU: op = ALU_SUB;
					FN_AND: op = ALU_AND;
					FN_OR: op = ALU_OR;
					FN_XOR: op = ALU_XOR;
					FN_NOR: op = ALU_NOR;
					FN_SLT: op = ALU_SLT;
					FN_SLTU: op = ALU_SLTU;
					FN_SLL: op = ALU_SLL;
					FN_SRL: op = ALU_SRL;
					FN_SRA: op = ALU_SRA;
					default: write_en = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				operand_b = imm_sext;
				write_en = 1'b1;
			end
			OP_SLTI: begin
				op = ALU_SLT;
				operand_b = imm_sext;
				write_en = 1'b1;
			end
			OP_ORI: begin
				op = ALU_OR;
				operand_b = imm_zext;
				write_en = 1'b1;
			end
			OP_XORI: begin
				op = ALU_XOR;
				operand_b = imm_zext;
				write_en = 1'b1;
			end
			OP_LUI: begin
				op = ALU_LUI;
				operand_b = imm_zext;
				write_en = 1'b1;
			end
			default: write_en = 1'b0;	// Unsupported word retires quietly
		endcase
	end

	alu alu_inst (
		.op(op),
		.a(rs_data),
		.b(operand_b),
		.shamt(shamt),
		.result(result)
	);

	assign accept = link.req && !ack;
	assign link.ack = ack;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (accept && write_en && dest != '0) begin
			regs[dest] <= result;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ack <= 1'b0;
			retire_valid <= 1'b0;
			retire_we <= 1'b0;
			retire_last <= 1'b0;
			done <= 1'b0;
		end else begin
			retire_valid <= accept;
			retire_we <= accept && write_en && (dest != '0);
			if (accept) begin
				ack <= 1'b1;
				retire_last <= link.last;
			end else if (ack && !link.req) begin
				ack <= 1'b0;
			end
			// First word of the next program clears done
			if (accept) begin
				done <= 1'b0;
			end else if (retire_valid && retire_last) begin
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			retire_pc <= link.pc;
			retire_rd <= dest;
			retire_value <= result;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none

module fetch_unit (
	input logic clock,
	input logic reset,
	input logic start,
	input cpu_pkg::imem_addr_t prog_length,
	output cpu_pkg::imem_addr_t read_addr,
	input cpu_pkg::word_t read_data,
	insn_link_if.sender link
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		OFFER,
		RELEASE
	} state_t;

	state_t state;
	pc_t pc;
	imem_addr_t length;
	imem_addr_t word_index;
	logic req;
	word_t insn;

	assign word_index = pc[IMEM_ADDR_WIDTH+1:2];
	assign read_addr = word_index;

	assign link.req = req;
	assign link.pc = pc;
	assign link.insn = insn;
	assign link.last = (word_index == length - 1'b1);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			pc <= '0;
			length <= '0;
			req <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						pc <= '0;
						length <= prog_length;
						state <= READ;
					end
				end
				READ: state <= OFFER;	// Memory has the address this cycle
				OFFER: begin
					if (!req) begin
						req <= 1'b1;
					end else if (link.ack) begin
						req <= 1'b0;
						state <= RELEASE;
					end
				end
				RELEASE: begin
					// Transfer ends on the fall of ack
					if (!link.ack) begin
						if (link.last) begin
							state <= IDLE;
						end else begin
							pc <= pc + 32'd4;
							state <= READ;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == OFFER && !req) begin
			insn <= read_data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/insn_link_if.sv
`default_nettype none

// Four-phase req/ack link for one fetched instruction
interface insn_link_if;
	import cpu_pkg::*;

	logic req;
	logic ack;
	pc_t pc;
	word_t insn;
	logic last;	// Final word of the program

	modport sender (
		output req, pc, insn, last,
		input ack
	);

	modport receiver (
		input req, pc, insn, last,
		output ack
	);

endinterface

`default_nettype wire

// File: hdl/insn_memory.sv
`default_nettype none

module insn_memory (
	input logic clock,
	input logic write_en,
	input cpu_pkg::imem_addr_t write_addr,
	input cpu_pkg::word_t write_data,
	input cpu_pkg::imem_addr_t read_addr,
	output cpu_pkg::word_t read_data
);
	import cpu_pkg::*;

	word_t mem [IMEM_DEPTH];

	// Load port, only used while the core is idle
	always_ff @(posedge clock) begin
		if (write_en) begin
			mem[write_addr] <= write_data;
		end
	end

	always_ff @(posedge clock) begin
		read_data <= mem[read_addr];	// One cycle read latency
	end

endmodule

`default_nettype wire

// File: hdl/insn_queue.sv
`default_nettype none

module insn_queue (
	input logic clock,
	input logic reset,
	insn_link_if.receiver in_link,
	insn_link_if.sender out_link
);
	import cpu_pkg::*;

	typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;

	pc_t pc_q [QUEUE_DEPTH];
	word_t insn_q [QUEUE_DEPTH];
	logic last_q [QUEUE_DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	logic [$clog2(QUEUE_DEPTH+1)-1:0] count;
	logic in_ack;
	logic out_req;
	logic push;
	logic pop;

	function automatic ptr_t next_ptr(input ptr_t ptr);
		return (ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// No ack while full, so the fetch unit holds req
	assign push = in_link.req && !in_ack && (count != QUEUE_DEPTH);
	assign pop = out_req && out_link.ack;	// Head leaves on the rise of ack

	assign in_link.ack = in_ack;
	assign out_link.req = out_req;
	assign out_link.pc = pc_q[rd_ptr];
	assign out_link.insn = insn_q[rd_ptr];
	assign out_link.last = last_q[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			pc_q[wr_ptr] <= in_link.pc;
			insn_q[wr_ptr] <= in_link.insn;
			last_q[wr_ptr] <= in_link.last;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_ack <= 1'b0;
			out_req <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
				in_ack <= 1'b1;
			end else if (in_ack && !in_link.req) begin
				in_ack <= 1'b0;
			end

			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
				out_req <= 1'b0;
			end else if (!out_req && !out_link.ack && count != 0) begin
				out_req <= 1'b1;	// Previous cycle fully closed
			end

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: list.f
hdl/cpu_pkg.sv
hdl/insn_link_if.sv
hdl/insn_memory.sv
hdl/fetch_unit.sv
hdl/insn_queue.sv
hdl/alu.sv
hdl/execute_unit.sv
hdl/cpu_top.sv
bench/clock_gen.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f list.f -o cpu_sim \
	&& ./obj_dir/cpu_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
